// ==== src/ups_pkg.sv ====
// --------------------
// Shared types and constants for the UPS pulse controller
// DAC and ADC codes are 12-bit unsigned
// Run phase lengths are whole seconds, 8 bits each
// --------------------
`default_nettype none

package ups_pkg;

    // --------------------
    // Data types
    // --------------------
    typedef logic [11:0] dac_word_t;                // One DAC or ADC code

    typedef struct packed {
        logic      valid;                           // Single-cycle write strobe
        dac_word_t data;
    } dac_wr_t;

    typedef struct packed {
        logic [7:0] loops;                          // Number of pulse cycles
        logic [7:0] pre;                            // Seconds before the pulse
        logic [7:0] pulse;                          // Seconds with valve open
        logic [7:0] post;                           // Seconds after the pulse
    } run_cfg_t;

    // --------------------
    // Opcodes and states
    // --------------------
    typedef enum logic [1:0] {
        MODE_IDLE     = 2'd0,
        MODE_LOOPBACK = 2'd1,
        MODE_DAC_TEST = 2'd2,
        MODE_RUN      = 2'd3
    } mode_e;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_LOOPBACK,
        CTRL_DAC_TEST,
        CTRL_RUN
    } ctrl_state_e;

    typedef enum logic [2:0] {
        SEQ_INIT,
        SEQ_WAIT,
        SEQ_PRE,
        SEQ_PULSE,
        SEQ_POST
    } seq_state_e;

    typedef enum logic [2:0] {
        ST_OFF   = 3'd0,
        ST_WAIT  = 3'd1,                            // Armed, waiting for start
        ST_PRE   = 3'd2,
        ST_PULSE = 3'd3,
        ST_POST  = 3'd4
    } status_e;

    // --------------------
    // DAC and ADC constants
    // --------------------
    localparam dac_word_t TWO_VOLT  = 12'h9B2;      // Start pulse level
    localparam dac_word_t ONE_VOLT  = 12'h505;      // Level held into the pulse
    localparam dac_word_t CONV_GAIN = 12'h9B2;      // About 2/3.3 in Q0.12

endpackage

`default_nettype wire

// ==== src/adc_scaler.sv ====
// --------------------
// Scales each ADC sample by CONV_GAIN and drops 12 fraction bits
// Three register stages, fully pipelined
// No back-pressure, every sample is accepted
// --------------------
`timescale 1ns/10ps
`default_nettype none

module adc_scaler import ups_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  dac_word_t adc,
    input  logic      adc_dv,
    output dac_wr_t   scaled
);

    dac_word_t   adc_q;                             // Stage 1 sample
    logic [23:0] prod_q;                            // Stage 2 full product
    dac_word_t   data_q;                            // Stage 3 sliced result
    logic [2:0]  dv_sr;                             // Valid alongside the data

    // Valid shift register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dv_sr <= '0;
        end else begin
            dv_sr <= {dv_sr[1:0], adc_dv};
        end
    end

    // Data path, no reset needed behind the valid bits
    always_ff @(posedge clk) begin
        adc_q  <= adc;
        prod_q <= adc_q * CONV_GAIN;                // 12 x 12 into 24 bits
        data_q <= prod_q[23:12];                    // Divide by 4096
    end

    assign scaled = '{valid: dv_sr[2], data: data_q};

    // Every accepted sample comes out exactly three cycles later, with its own data
    a_scaler_latency: assert property (@(posedge clk) disable iff (!rst_n)
        adc_dv |-> ##3 (scaled.valid
                        && scaled.data == dac_word_t'((24'($past(adc, 3)) * CONV_GAIN) >> 12)));

endmodule

`default_nettype wire

// ==== src/boxcar_filter.sv ====
// --------------------
// Running average over the last 2**AVG_LOG2 scaled samples
// The current sample is part of the sum
// Samples before reset count as zero
// --------------------
`timescale 1ns/10ps
`default_nettype none

module boxcar_filter import ups_pkg::*; #(
    parameter int AVG_LOG2 = 4
) (
    input  logic    clk,
    input  logic    rst_n,
    input  dac_wr_t scaled,
    output dac_wr_t filtered
);

    localparam int DEPTH = 2 ** AVG_LOG2;
    localparam int ACC_W = 12 + AVG_LOG2;           // Room for DEPTH full-scale codes

    dac_word_t        taps [DEPTH];                 // Newest sample at index 0
    logic [ACC_W-1:0] acc;                          // Sum of all taps
    logic [ACC_W-1:0] sum_next;

    // New sum in, oldest tap out
    always_comb begin
        sum_next = acc + {{AVG_LOG2{1'b0}}, scaled.data}
                       - {{AVG_LOG2{1'b0}}, taps[DEPTH-1]};
    end

    // --------------------
    // Delay line and accumulator
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc            <= '0;
            filtered.valid <= 1'b0;
            for (int i = 0; i < DEPTH; i++) begin
                taps[i] <= '0;                      // Zero history defines the start-up sum
            end
        end else begin
            filtered.valid <= 1'b0;
            if (scaled.valid) begin
                acc     <= sum_next;
                taps[0] <= scaled.data;
                for (int i = 1; i < DEPTH; i++) begin
                    taps[i] <= taps[i-1];
                end
                filtered.valid <= 1'b1;
                filtered.data  <= sum_next[ACC_W-1:AVG_LOG2];   // Truncating divide
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/run_sequencer.sv ====
// --------------------
// Run mode pulse sequence, pre-pulse then pulse then post-pulse, looped
// Each phase lasts seconds x TICKS_PER_SEC + 1 cycles
// Held in SEQ_INIT whenever run_en is low
// run_stop in an active phase wins over every other action
// --------------------
`timescale 1ns/10ps
`default_nettype none

module run_sequencer import ups_pkg::*; #(
    parameter int TICKS_PER_SEC = 100_000_000
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     run_en,
    input  run_cfg_t run_cfg,
    input  logic     run_start,
    input  logic     run_stop,
    input  dac_wr_t  filtered,
    output dac_wr_t  seq_dac0,
    output dac_wr_t  seq_dac1,
    output logic     seq_pv,
    output status_e  seq_status
);

    localparam int CNT_W = 8 + $clog2(TICKS_PER_SEC + 1);    // 255 s worth of ticks
    localparam logic [CNT_W-1:0] ONE_SEC = CNT_W'(TICKS_PER_SEC);

    seq_state_e       state;
    logic [CNT_W-1:0] cnt;                          // Cycle within the phase
    logic [CNT_W-1:0] pre_lim;
    logic [CNT_W-1:0] pulse_lim;
    logic [CNT_W-1:0] post_lim;
    logic [7:0]       loops_q;                      // Loops left including this one

    // --------------------
    // Phase FSM
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state          <= SEQ_INIT;
            cnt            <= '0;
            seq_dac0.valid <= 1'b0;
            seq_dac1.valid <= 1'b0;
            seq_pv         <= 1'b0;
            seq_status     <= ST_OFF;
        end else begin
            seq_dac0.valid <= 1'b0;                 // Strobes by default off
            seq_dac1.valid <= 1'b0;
            seq_pv         <= 1'b0;                 // Valve normally closed
            seq_status     <= ST_OFF;
            if (!run_en) begin
                state <= SEQ_INIT;
            end else begin
                case (state)
                    SEQ_INIT: begin
                        seq_dac0   <= '{valid: 1'b1, data: '0};     // Park both DACs
                        seq_dac1   <= '{valid: 1'b1, data: '0};
                        seq_status <= ST_WAIT;
                        state      <= SEQ_WAIT;
                    end
                    SEQ_WAIT: begin
                        seq_status <= ST_WAIT;
                        if (run_start) begin
                            loops_q   <= run_cfg.loops;
                            pre_lim   <= CNT_W'(run_cfg.pre) * ONE_SEC;
                            pulse_lim <= CNT_W'(run_cfg.pulse) * ONE_SEC;
                            post_lim  <= CNT_W'(run_cfg.post) * ONE_SEC;
                            cnt       <= '0;
                            state     <= SEQ_PRE;
                        end
                    end
                    SEQ_PRE: begin
                        seq_status <= ST_PRE;
                        if (cnt == '0) begin
                            seq_dac1 <= '{valid: 1'b1, data: TWO_VOLT};  // Start pulse
                        end
                        if (cnt == ONE_SEC) begin
                            seq_dac1 <= '{valid: 1'b1, data: '0};        // End of 1 s start
                        end
                        if (cnt == pre_lim) begin
                            seq_dac1 <= '{valid: 1'b1, data: ONE_VOLT};  // Last write wins
                            cnt      <= '0;
                            state    <= SEQ_PULSE;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                    SEQ_PULSE: begin
                        seq_status <= ST_PULSE;
                        seq_pv     <= 1'b1;
                        if (cnt == pulse_lim) begin
                            seq_dac0 <= '{valid: 1'b1, data: '0};        // Close out the pulse
                            seq_dac1 <= '{valid: 1'b1, data: '0};
                            cnt      <= '0;
                            state    <= SEQ_POST;
                        end else begin
                            seq_dac0 <= filtered;                        // Pressure feed-through
                            cnt      <= cnt + 1'b1;
                        end
                    end
                    SEQ_POST: begin
                        seq_status <= ST_POST;
                        if (cnt == post_lim) begin
                            cnt <= '0;
                            if (loops_q > 8'd1) begin
                                loops_q <= loops_q - 8'd1;
                                state   <= SEQ_PRE;
                            end else begin
                                state <= SEQ_WAIT;
                            end
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                    default: state <= SEQ_INIT;
                endcase

                // Stop overrides the phase actions above
                if (run_stop && (state inside {SEQ_PRE, SEQ_PULSE, SEQ_POST})) begin
                    seq_dac0.valid <= 1'b0;
                    seq_dac1.valid <= 1'b0;
                    seq_pv         <= 1'b0;
                    state          <= SEQ_INIT;
                end
            end
        end
    end

    // Valve opens only for cycles spent in the pulse phase
    a_pv_in_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        seq_pv |-> $past(state == SEQ_PULSE));

endmodule

`default_nettype wire

// ==== src/mode_controller.sv ====
// --------------------
// Mode FSM selecting the DAC, valve and status sources
// All outputs are registered, one cycle behind their source
// mode_update forces idle and clears every strobe
// --------------------
`timescale 1ns/10ps
`default_nettype none

module mode_controller import ups_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  mode_e   mode,
    input  logic    mode_update,
    input  dac_wr_t filtered,
    input  dac_wr_t dac0_test,
    input  dac_wr_t dac1_test,
    input  logic    pv_test,
    input  dac_wr_t seq_dac0,
    input  dac_wr_t seq_dac1,
    input  logic    seq_pv,
    input  status_e seq_status,
    output logic    run_en,
    output dac_wr_t dac0,
    output dac_wr_t dac1,
    output logic    pv,
    output status_e status
);

    ctrl_state_e state;

    assign run_en = (state == CTRL_RUN);            // Releases the sequencer from init

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= CTRL_IDLE;
            dac0.valid <= 1'b0;
            dac1.valid <= 1'b0;
            pv         <= 1'b0;
            status     <= ST_OFF;
        end else begin
            dac0.valid <= 1'b0;
            dac1.valid <= 1'b0;
            pv         <= 1'b0;
            status     <= ST_OFF;                   // Off outside run mode
            if (mode_update) begin
                state <= CTRL_IDLE;
            end else begin
                case (state)
                    CTRL_IDLE: begin
                        case (mode)
                            MODE_LOOPBACK: state <= CTRL_LOOPBACK;
                            MODE_DAC_TEST: state <= CTRL_DAC_TEST;
                            MODE_RUN:      state <= CTRL_RUN;
                            default:       state <= CTRL_IDLE;
                        endcase
                    end
                    CTRL_LOOPBACK: begin
                        dac0 <= filtered;           // Same sample on both channels
                        dac1 <= filtered;
                        pv   <= pv_test;
                    end
                    CTRL_DAC_TEST: begin
                        dac0 <= dac0_test;
                        dac1 <= dac1_test;
                        pv   <= pv_test;
                    end
                    CTRL_RUN: begin
                        dac0   <= seq_dac0;
                        dac1   <= seq_dac1;
                        pv     <= seq_pv;
                        status <= seq_status;
                    end
                endcase
            end
        end
    end

    // Idle entered by reset or mode_update never carries a write
    a_idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (state == CTRL_IDLE) |-> !(dac0.valid || dac1.valid));

endmodule

`default_nettype wire

// ==== src/ups_top.sv ====
// --------------------
// UPS pulse controller top level
// TICKS_PER_SEC sets the clock rate in cycles per second
// AVG_LOG2 sets the boxcar depth as a power of two
// --------------------
`timescale 1ns/10ps
`default_nettype none

module ups_top import ups_pkg::*; #(
    parameter int TICKS_PER_SEC = 100_000_000,
    parameter int AVG_LOG2      = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    // ADC sample stream
    input  dac_word_t adc,
    input  logic      adc_dv,
    // Mode select
    input  mode_e     mode,
    input  logic      mode_update,
    // Test mode inputs
    input  dac_wr_t   dac0_test,
    input  dac_wr_t   dac1_test,
    input  logic      pv_test,
    // Run mode control
    input  run_cfg_t  run_cfg,
    input  logic      run_start,
    input  logic      run_stop,
    // Outputs
    output dac_wr_t   dac0,
    output dac_wr_t   dac1,
    output logic      pv,
    output status_e   status
);

    dac_wr_t scaled;
    dac_wr_t filtered;
    dac_wr_t seq_dac0;
    dac_wr_t seq_dac1;
    logic    seq_pv;
    status_e seq_status;
    logic    run_en;

    // --------------------
    // ADC path
    // --------------------
    adc_scaler u_adc_scaler (
        .clk    (clk),
        .rst_n  (rst_n),
        .adc    (adc),
        .adc_dv (adc_dv),
        .scaled (scaled)
    );

    boxcar_filter #(
        .AVG_LOG2 (AVG_LOG2)
    ) u_boxcar_filter (
        .clk      (clk),
        .rst_n    (rst_n),
        .scaled   (scaled),
        .filtered (filtered)
    );

    // --------------------
    // Control
    // --------------------
    run_sequencer #(
        .TICKS_PER_SEC (TICKS_PER_SEC)
    ) u_run_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .run_en     (run_en),
        .run_cfg    (run_cfg),
        .run_start  (run_start),
        .run_stop   (run_stop),
        .filtered   (filtered),
        .seq_dac0   (seq_dac0),
        .seq_dac1   (seq_dac1),
        .seq_pv     (seq_pv),
        .seq_status (seq_status)
    );

    mode_controller u_mode_controller (
        .clk         (clk),
        .rst_n       (rst_n),
        .mode        (mode),
        .mode_update (mode_update),
        .filtered    (filtered),
        .dac0_test   (dac0_test),
        .dac1_test   (dac1_test),
        .pv_test     (pv_test),
        .seq_dac0    (seq_dac0),
        .seq_dac1    (seq_dac1),
        .seq_pv      (seq_pv),
        .seq_status  (seq_status),
        .run_en      (run_en),
        .dac0        (dac0),
        .dac1        (dac1),
        .pv          (pv),
        .status      (status)
    );

endmodule

`default_nettype wire

// ==== dv/ups_tb.sv ====
// --------------------
// Table-driven testbench for the UPS pulse controller
// TICKS_PER_SEC is 4, so each phase lasts seconds x 4 + 1 cycles
// Model filter history is never cleared, like the DUT after reset
// Every row ends with idle ADC cycles so no sample crosses rows
// --------------------
`timescale 1ns/10ps
`default_nettype none

module ups_tb import ups_pkg::*; ();

    localparam int TICKS   = 4;
    localparam int N_ROWS  = 4;
    localparam int MAX_CYC = 1024;

    typedef struct packed {
        mode_e            mode;
        run_cfg_t         cfg;
        logic [7:0]       n_samples;                // ADC samples from row start
        logic [7:0]       stop_at;                  // Row cycle of run_stop, 0 for none
        logic [7:0]       len;                      // Row length in cycles
        logic [3:0]       n_d1;
        logic [0:9][11:0] d1_seq;                   // Expected DAC1 writes in order
        logic [3:0]       n_st;
        logic [0:7][2:0]  st_seq;                   // Expected status changes
    } row_t;

    logic      clk;
    logic      rst_n;
    dac_word_t adc;
    logic      adc_dv;
    mode_e     mode;
    logic      mode_update;
    dac_wr_t   dac0_test;
    dac_wr_t   dac1_test;
    logic      pv_test;
    run_cfg_t  run_cfg;
    logic      run_start;
    logic      run_stop;
    dac_wr_t   dac0;
    dac_wr_t   dac1;
    logic      pv;
    status_e   status;

    row_t        rows [N_ROWS];
    logic [31:0] seed;
    int          cyc;
    int          errors;
    int          checks;
    int          limit = 100000;
    int          wd_cnt = 0;
    dac_word_t   hist [16];                         // Model boxcar, newest at 0
    dac_wr_t     filt [MAX_CYC];                    // Model filter output, by edge that sees it
    dac_wr_t     exp0 [MAX_CYC];                    // Test writes, by output edge
    dac_wr_t     exp1 [MAX_CYC];
    logic        exp_pv [MAX_CYC];

    ups_top #(
        .TICKS_PER_SEC (TICKS),
        .AVG_LOG2      (4)
    ) u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .adc         (adc),
        .adc_dv      (adc_dv),
        .mode        (mode),
        .mode_update (mode_update),
        .dac0_test   (dac0_test),
        .dac1_test   (dac1_test),
        .pv_test     (pv_test),
        .run_cfg     (run_cfg),
        .run_start   (run_start),
        .run_stop    (run_stop),
        .dac0        (dac0),
        .dac1        (dac1),
        .pv          (pv),
        .status      (status)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Watchdog on total cycles
    always @(posedge clk) begin
        wd_cnt <= wd_cnt + 1;
        if (wd_cnt > limit) begin
            $display("Timeout, the run went past %0d cycles without finishing", limit);
            $display("sim failed");
            $finish;
        end
    end

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic string mode_label(input mode_e m);
        case (m)
            MODE_LOOPBACK: return "loopback";
            MODE_DAC_TEST: return "dac test";
            MODE_RUN:      return "run";
            default:       return "idle";
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%0h expected 0x%0h at cycle %0d", name, got, exp, cyc);
        end
    endtask

    task automatic tick();
        @(posedge clk);
        cyc++;
        #1;                                         // Outputs settled, inputs go here
    endtask

    task automatic check_quiet();
        check("dac0.valid", dac0.valid, 1'b0);
        check("dac1.valid", dac1.valid, 1'b0);
        check("pv", pv, 1'b0);
        check("status", status, ST_OFF);
    endtask

    // Gain, then 16-deep average including this sample
    task automatic model_sample(input dac_word_t s, input int at_edge);
        logic [23:0] prod;
        logic [15:0] sum;
        prod = 24'(s) * 24'(CONV_GAIN);
        for (int i = 15; i > 0; i--) begin
            hist[i] = hist[i-1];
        end
        hist[0] = prod[23:12];
        sum = '0;
        for (int i = 0; i < 16; i++) begin
            sum = sum + 16'(hist[i]);
        end
        filt[at_edge] = '{valid: 1'b1, data: sum[15:4]};
    endtask

    // --------------------
    // One table row
    // --------------------
    task automatic run_row(input int r);
        row_t      row;
        int        c0;
        int        err0;
        int        n_wr;
        int        pv_len;
        int        pv_runs;
        int        wr0_at;
        int        wr1_at;
        dac_word_t wr0_d;
        status_e   st_prev;
        dac_word_t d1_got [$];
        status_e   st_got [$];
        row = rows[r];
        c0 = cyc;
        err0 = errors;
        n_wr = 0;
        pv_len = 0;
        pv_runs = 0;
        wr0_at = -1;
        wr1_at = -2;
        wr0_d = '1;
        st_prev = ST_OFF;
        for (int t = 0; t < row.len; t++) begin
            if (t == 1 || t == 2) begin
                check_quiet();                      // mode_update edge, then idle
            end else if (t >= 3 && row.mode == MODE_LOOPBACK) begin
                check("dac0.valid", dac0.valid, filt[cyc].valid);
                check("dac1.valid", dac1.valid, filt[cyc].valid);   // Both channels identical
                if (filt[cyc].valid) begin
                    check("dac0.data", dac0.data, filt[cyc].data);
                    check("dac1.data", dac1.data, filt[cyc].data);
                end
                if (dac0.valid && dac1.valid) begin
                    n_wr++;
                end
                check("pv", pv, exp_pv[cyc]);
                check("status", status, ST_OFF);
            end else if (t >= 3 && row.mode == MODE_DAC_TEST) begin
                check("dac0.valid", dac0.valid, exp0[cyc].valid);
                check("dac1.valid", dac1.valid, exp1[cyc].valid);
                if (exp0[cyc].valid) begin
                    check("dac0.data", dac0.data, exp0[cyc].data);
                end
                if (exp1[cyc].valid) begin
                    check("dac1.data", dac1.data, exp1[cyc].data);
                end
                check("pv", pv, exp_pv[cyc]);
                check("status", status, ST_OFF);
            end else if (t >= 3) begin
                if (status != st_prev) begin
                    st_got.push_back(status);
                    st_prev = status;
                end
                if (dac1.valid) begin
                    d1_got.push_back(dac1.data);
                    wr1_at = cyc;
                end
                if (dac0.valid) begin
                    wr0_at = cyc;
                    wr0_d = dac0.data;
                end
                if (pv && dac1.valid) begin         // Last pulse cycle
                    check("dac0.valid", dac0.valid, 1'b1);
                    check("dac0.data", dac0.data, 12'h000);
                end else if (pv) begin              // Filtered feed-through, one extra stage
                    check("dac0.valid", dac0.valid, filt[cyc-1].valid);
                    if (filt[cyc-1].valid) begin
                        check("dac0.data", dac0.data, filt[cyc-1].data);
                    end
                end
                if (pv) begin
                    pv_len++;
                end else if (pv_len != 0) begin
                    if (row.stop_at == 0) begin
                        check("pv high cycles", pv_len, TICKS * row.cfg.pulse + 1);
                    end
                    pv_runs++;
                    pv_len = 0;
                end
            end

            // Inputs for the next edge
            mode_update = (t == 0);
            mode        = row.mode;
            run_cfg     = row.cfg;
            run_start   = (row.mode == MODE_RUN) && (t == 5);
            run_stop    = (row.stop_at != 0) && (t == row.stop_at);
            adc_dv      = (t < row.n_samples);
            if (adc_dv) begin
                seed = lcg_next(seed);
                adc = seed[27:16];
                model_sample(adc, cyc + 5);         // Scaler 3, filter 1, sampling edge
            end
            seed = lcg_next(seed);
            pv_test   = seed[20];
            dac0_test = '{valid: (t % 3 != 1), data: seed[11:0]};   // 0 alone, 1 alone, both
            dac1_test = '{valid: (t % 3 != 0), data: seed[31:20]};
            exp_pv[cyc+1] = pv_test;
            exp0[cyc+1]   = dac0_test;
            exp1[cyc+1]   = dac1_test;
            tick();
        end

        // Sequence checks at the end of the row
        if (row.mode == MODE_LOOPBACK) begin
            check("loopback writes", n_wr, row.n_samples);
        end
        if (row.mode == MODE_RUN) begin
            check("dac1 write count", d1_got.size(), row.n_d1);
            for (int i = 0; i < row.n_d1 && i < d1_got.size(); i++) begin
                check($sformatf("dac1 write %0d", i), d1_got[i], row.d1_seq[i]);
            end
            check("status change count", st_got.size(), row.n_st);
            for (int i = 0; i < row.n_st && i < st_got.size(); i++) begin
                check($sformatf("status change %0d", i), st_got[i], row.st_seq[i]);
            end
            check("pv pulses", pv_runs, (row.stop_at == 0) ? row.cfg.loops : 1);
            if (row.stop_at != 0) begin
                check("stop write cycle", wr0_at, wr1_at);    // Zero on both together
                check("dac0 stop data", wr0_d, 12'h000);
            end
        end
        $display("test %0d %s: %0d errors", r + 1, mode_label(row.mode), errors - err0);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        adc         = '0;
        adc_dv      = 1'b0;
        mode        = MODE_IDLE;
        mode_update = 1'b0;
        dac0_test   = '0;
        dac1_test   = '0;
        pv_test     = 1'b0;
        run_cfg     = '0;
        run_start   = 1'b0;
        run_stop    = 1'b0;
        rst_n       = 1'b0;
        seed        = 32'h5be6_6f03;
        cyc         = 0;
        errors      = 0;
        checks      = 0;

        rows[0] = '{mode: MODE_LOOPBACK, cfg: '0, n_samples: 8'd40, stop_at: 8'd0,
                    len: 8'd55, n_d1: 4'd0, d1_seq: '0, n_st: 4'd0, st_seq: '0};
        rows[1] = '{mode: MODE_DAC_TEST, cfg: '0, n_samples: 8'd0, stop_at: 8'd0,
                    len: 8'd30, n_d1: 4'd0, d1_seq: '0, n_st: 4'd0, st_seq: '0};
        rows[2] = '{mode: MODE_RUN,
                    cfg: '{loops: 8'd2, pre: 8'd2, pulse: 8'd1, post: 8'd1},
                    n_samples: 8'd50, stop_at: 8'd0, len: 8'd60, n_d1: 4'd9,
                    d1_seq: {12'h000, TWO_VOLT, 12'h000, ONE_VOLT, 12'h000,
                             TWO_VOLT, 12'h000, ONE_VOLT, 12'h000, 12'h000},
                    n_st: 4'd8,
                    st_seq: {ST_WAIT, ST_PRE, ST_PULSE, ST_POST,
                             ST_PRE, ST_PULSE, ST_POST, ST_WAIT}};
        // Stop lands on the third pulse cycle
        rows[3] = '{mode: MODE_RUN,
                    cfg: '{loops: 8'd2, pre: 8'd2, pulse: 8'd1, post: 8'd1},
                    n_samples: 8'd30, stop_at: 8'd17, len: 8'd40, n_d1: 4'd5,
                    d1_seq: {12'h000, TWO_VOLT, 12'h000, ONE_VOLT, 12'h000,
                             12'h000, 12'h000, 12'h000, 12'h000, 12'h000},
                    n_st: 4'd4,
                    st_seq: {ST_WAIT, ST_PRE, ST_PULSE, ST_WAIT,
                             ST_OFF, ST_OFF, ST_OFF, ST_OFF}};

        limit = 5 + 200;                            // Reset cycles plus margin
        for (int r = 0; r < N_ROWS; r++) begin
            limit = limit + rows[r].len;
        end
        for (int i = 0; i < MAX_CYC; i++) begin
            filt[i]   = '0;
            exp0[i]   = '0;
            exp1[i]   = '0;
            exp_pv[i] = 1'b0;
        end
        for (int i = 0; i < 16; i++) begin
            hist[i] = '0;
        end

        repeat (4) tick();
        check_quiet();
        rst_n = 1'b1;
        tick();
        check_quiet();
        $display("test 0 reset: %0d errors", errors);

        for (int r = 0; r < N_ROWS; r++) begin
            run_row(r);
        end

        $display("tests %0d, checks %0d, errors %0d", N_ROWS + 1, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
src/ups_pkg.sv
src/adc_scaler.sv
src/boxcar_filter.sv
src/run_sequencer.sv
src/mode_controller.sv
src/ups_top.sv
dv/ups_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the UPS testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module ups_tb
rc=$?
if [ $rc -ne 0 ]; then
    echo "Verilator build failed with status $rc"
    exit 1
fi

out=$(./obj_dir/Vups_tb)
rc=$?
echo "$out"
if [ $rc -ne 0 ]; then
    echo "Simulation exited with status $rc"
    exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
